// File: alu_decoder.sv
`timescale 1ns/10ps

module alu_decoder (
    input  rv_decode_pkg::instr_word_t    instr,
    output rv_decode_pkg::decode_result_t result
);
    import rv_decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       f7_base;
    logic       f7_alt;
    logic       sh6_base;
    logic       sh6_alt;
    logic       imm_src;
    logic       word;
    op_t        op;
    alu_op_t    aluop;
    imm_fmt_t   fmt;

    assign opcode = instr[6:0];
    assign f3     = instr[14:12];
    assign f7     = instr[31:25];

    assign f7_base = (f7 == F7_BASE);
    assign f7_alt  = (f7 == F7_ALT);
    // Six-bit shamt borrows funct7 bit 0.
    assign sh6_base = ({f7[6:1], 1'b0} == F7_BASE);
    assign sh6_alt  = ({f7[6:1], 1'b0} == F7_ALT);

    assign imm_src = (opcode == OPC_OP_IMM) || (opcode == OPC_OP_IMM_32);
    assign word    = (opcode == OPC_OP_IMM_32) || (opcode == OPC_OP_32);

    // Legal encodings only. M-extension funct7 falls to OP_NONE.
    always_comb begin
        op = OP_NONE;
        unique case (opcode)
            OPC_OP_IMM: begin
                unique case (f3)
                    F3_ADD:  op = OP_ADDI;
                    F3_SLT:  op = OP_SLTI;
                    F3_SLTU: op = OP_SLTIU;
                    F3_XOR:  op = OP_XORI;
                    F3_OR:   op = OP_ORI;
                    F3_AND:  op = OP_ANDI;
                    F3_SLL:  op = sh6_base ? OP_SLLI : OP_NONE;
                    F3_SRL:  op = sh6_base ? OP_SRLI : (sh6_alt ? OP_SRAI : OP_NONE);
                endcase
            end
            OPC_OP: begin
                unique case (f3)
                    F3_ADD:  op = f7_base ? OP_ADD : (f7_alt ? OP_SUB : OP_NONE);
                    F3_SLL:  op = f7_base ? OP_SLL : OP_NONE;
                    F3_SLT:  op = f7_base ? OP_SLT : OP_NONE;
                    F3_SLTU: op = f7_base ? OP_SLTU : OP_NONE;
                    F3_XOR:  op = f7_base ? OP_XOR : OP_NONE;
                    F3_SRL:  op = f7_base ? OP_SRL : (f7_alt ? OP_SRA : OP_NONE);
                    F3_OR:   op = f7_base ? OP_OR : OP_NONE;
                    F3_AND:  op = f7_base ? OP_AND : OP_NONE;
                endcase
            end
            OPC_OP_IMM_32: begin
                unique case (f3)
                    F3_ADD:  op = OP_ADDIW;
                    F3_SLL:  op = f7_base ? OP_SLLIW : OP_NONE;
                    F3_SRL:  op = f7_base ? OP_SRLIW : (f7_alt ? OP_SRAIW : OP_NONE);
                    default: op = OP_NONE;
                endcase
            end
            OPC_OP_32: begin
                unique case (f3)
                    F3_ADD:  op = f7_base ? OP_ADDW : (f7_alt ? OP_SUBW : OP_NONE);
                    F3_SLL:  op = f7_base ? OP_SLLW : OP_NONE;
                    F3_SRL:  op = f7_base ? OP_SRLW : (f7_alt ? OP_SRAW : OP_NONE);
                    default: op = OP_NONE;
                endcase
            end
            default: op = OP_NONE;
        endcase
    end

    // ALU function follows funct3; bit 30 picks SUB or arithmetic shift.
    always_comb begin
        aluop = ALU_ADD;
        case (f3)
            F3_ADD:  aluop = (!imm_src && f7[5]) ? ALU_SUB : ALU_ADD;
            F3_SLL:  aluop = word ? ALU_SLLW : ALU_SLL;
            F3_SLT:  aluop = ALU_SLT;
            F3_SLTU: aluop = ALU_SLTU;
            F3_XOR:  aluop = ALU_XOR;
            F3_SRL:  aluop = f7[5] ? (word ? ALU_SRAW : ALU_SRA) : (word ? ALU_SRLW : ALU_SRL);
            F3_OR:   aluop = ALU_OR;
            F3_AND:  aluop = ALU_AND;
            default: aluop = ALU_ADD;
        endcase
    end

    always_comb begin
        fmt = IMM_NONE;
        if (imm_src) begin
            if (f3 == F3_SLL || f3 == F3_SRL) begin
                fmt = word ? IMM_SHAMT5 : IMM_SHAMT6;
            end else begin
                fmt = IMM_I;
            end
        end
    end

    always_comb begin
        result = '0;
        if (op != OP_NONE) begin
            result.hit              = 1'b1;
            result.op               = op;
            result.imm_fmt          = fmt;
            result.uses_rs1         = 1'b1;
            result.uses_rs2         = !imm_src;
            result.ctl.alusrc       = imm_src ? SRC_IMM : SRC_REG;
            result.ctl.aluop        = aluop;
            result.ctl.regwrite_en  = 1'b1;
            result.ctl.is_32instr   = word;
        end
    end

endmodule

// File: clk_gen.sv
`timescale 1ns/10ps

module clk_gen (
    output logic clk
);
    localparam realtime HALF_PERIOD = 4.0; // 8 ns period.

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// File: decode_chk.sv
`timescale 1ns/10ps

module decode_chk (
    input logic                          clk,
    input logic                          reset,
    input logic                          in_valid,
    input logic                          out_valid,
    input rv_decode_pkg::decoded_instr_t out_instr
);
    import rv_decode_pkg::*;

    int fail_count = 0; // Failed assertions so far.

    valid_follows_in: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> out_valid == $past(in_valid))
        else begin
            $error("out_valid does not follow in_valid by one cycle");
            fail_count++;
        end

    // First cycle out of reset.
    valid_low_after_reset: assert property (@(posedge clk)
        $past(reset) && !reset |-> !out_valid)
        else begin
            $error("out_valid high right after reset");
            fail_count++;
        end

    mem_enables_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(out_instr.ctl.memr_en && out_instr.ctl.memw_en))
        else begin
            $error("memr_en and memw_en both high");
            fail_count++;
        end

    none_means_zero: assert property (@(posedge clk) disable iff (reset)
        out_instr.op == OP_NONE |-> out_instr == '0)
        else begin
            $error("OP_NONE record is not all zero");
            fail_count++;
        end

endmodule

bind decode_stage decode_chk decode_chk0 (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_instr (out_instr)
);

// File: decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    input  rv_decode_pkg::instr_word_t    in_instr,
    output logic                          out_valid,
    output rv_decode_pkg::decoded_instr_t out_instr
);
    import rv_decode_pkg::*;

    decode_result_t alu_res;
    decode_result_t fm_res;
    decode_result_t sel;
    word_t          imm;
    decoded_instr_t rec;

    alu_decoder u_alu_decoder (
        .instr  (in_instr),
        .result (alu_res)
    );

    flow_mem_decoder u_flow_mem_decoder (
        .instr  (in_instr),
        .result (fm_res)
    );

    // Opcode sets are disjoint, so at most one hit.
    always_comb begin
        if (alu_res.hit) begin
            sel = alu_res;
        end else if (fm_res.hit) begin
            sel = fm_res;
        end else begin
            sel = '0;
        end
    end

    imm_gen u_imm_gen (
        .instr (in_instr),
        .fmt   (sel.imm_fmt),
        .imm   (imm)
    );

    always_comb begin
        rec = '0;
        if (sel.hit) begin
            rec.op       = sel.op;
            rec.ra1      = sel.uses_rs1 ? in_instr[19:15] : '0;
            rec.ra2      = sel.uses_rs2 ? in_instr[24:20] : '0;
            rec.writereg = sel.ctl.regwrite_en ? in_instr[11:7] : '0; // No rd for stores.
            rec.imm      = imm;
            rec.ctl      = sel.ctl;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_instr <= '0;
        end else begin
            out_valid <= in_valid;
            out_instr <= in_valid ? rec : '0; // Bubble on idle cycles.
        end
    end

endmodule

// File: decode_tb.sv
`timescale 1ns/10ps

module decode_tb;
    import rv_decode_pkg::*;

    localparam int FIELDS        = 8; // Columns per data line.
    localparam int MAX_LINES     = 64;
    localparam int RESET_TIMEOUT = 16;

    logic           clk;
    logic           reset;
    logic           in_valid;
    instr_word_t    in_instr;
    logic           out_valid;
    decoded_instr_t out_instr;

    logic [63:0] vec [0:FIELDS*MAX_LINES-1];
    int          n_lines;
    int          wait_cycles;

    clk_gen clk_gen0 (
        .clk (clk)
    );

    decode_stage dut0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .out_valid (out_valid),
        .out_instr (out_instr)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("ERR %0t %s got %h expected %h", $time, name, got, want);
        $display("Verification failed");
        $fatal(1, "%s mismatch", name);
    endtask

    task automatic check_valid(input logic got, input logic want);
        if (got !== want) report_mismatch("out_valid", got, want);
    endtask

    task automatic check_record(input decoded_instr_t got, input decoded_instr_t want);
        if (got.op !== want.op) report_mismatch("out_instr.op", got.op, want.op);
        if (got.ra1 !== want.ra1) report_mismatch("out_instr.ra1", got.ra1, want.ra1);
        if (got.ra2 !== want.ra2) report_mismatch("out_instr.ra2", got.ra2, want.ra2);
        if (got.writereg !== want.writereg) begin
            report_mismatch("out_instr.writereg", got.writereg, want.writereg);
        end
        if (got.imm !== want.imm) report_mismatch("out_instr.imm", got.imm, want.imm);
    endtask

    task automatic check_ctl(input control_t got, input control_t want);
        if (got !== want) report_mismatch("out_instr.ctl", got, want);
    endtask

    task automatic check_assertions();
        if (dut0.decode_chk0.fail_count != 0) begin
            abort_run("A bound assertion on the decode stage failed.");
        end
    endtask

    // One data line against the registered outputs.
    task automatic check_line(input int line);
        decoded_instr_t want;
        int             base;
        base          = line * FIELDS;
        want.op       = op_t'(vec[base+2][6:0]);
        want.ra1      = vec[base+3][4:0];
        want.ra2      = vec[base+4][4:0];
        want.writereg = vec[base+5][4:0];
        want.imm      = vec[base+6];
        want.ctl      = control_t'(vec[base+7][15:0]);
        check_valid(out_valid, vec[base][0]);
        check_record(out_instr, want);
        check_ctl(out_instr.ctl, want.ctl);
        check_assertions();
    endtask

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

    initial begin
        in_valid = 1'b0;
        in_instr = '0;
        $readmemh("decode_testdata.txt", vec);
        n_lines = 0;
        while (n_lines < MAX_LINES && !$isunknown(vec[n_lines*FIELDS])) begin
            n_lines++;
        end
        if (n_lines == 0) abort_run("No test data was read from decode_testdata.txt.");

        // Outputs stay cleared while reset is held.
        wait_cycles = 0;
        @(posedge clk);
        while (reset !== 1'b0) begin
            @(negedge clk);
            check_valid(out_valid, 1'b0);
            check_record(out_instr, '0);
            check_ctl(out_instr.ctl, '0);
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) abort_run("Reset never finished.");
            @(posedge clk);
        end

        // Line i is driven here and checked after the next edge.
        for (int i = 0; i <= n_lines; i++) begin
            if (i < n_lines) begin
                in_valid <= vec[i*FIELDS][0];
                in_instr <= vec[i*FIELDS+1][31:0];
            end else begin
                in_valid <= 1'b0;
                in_instr <= '0;
            end
            if (i > 0) begin
                @(negedge clk);
                check_line(i - 1);
            end
            @(posedge clk);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// File: decode_testdata.txt
// flag instr op ra1 ra2 writereg imm ctl; flag 1 is a valid cycle, 0 an idle one
// ctl is control_t packed; idle and rejected words expect an all-zero record
1 ffd30293 01 06 00 05 fffffffffffffffd 8004
1 03f11093 07 02 00 01 000000000000003f b804
1 4215d513 09 0b 00 0a 0000000000000021 c804
1 005201b3 0a 04 05 03 0000000000000000 0004
1 409403b3 0b 08 09 07 0000000000000000 0804
1 40e6d633 11 0d 0e 0c 0000000000000000 4804
1 7ff1009b 14 02 00 01 00000000000007ff 8005
1 41f2519b 17 04 00 03 000000000000001f e005
1 407302bb 19 06 07 05 0000000000000000 0805
1 40a4d43b 1c 09 0a 08 0000000000000000 6005
0 00000013 00 00 00 00 0000000000000000 0000
1 fff10083 1d 02 00 01 ffffffffffffffff 8026
1 00221183 1e 04 00 03 0000000000000002 8066
1 00432283 1f 06 00 05 0000000000000004 80a6
1 00843383 20 08 00 07 0000000000000008 80e6
1 01054483 21 0a 00 09 0000000000000010 802e
1 00065583 22 0c 00 0b 0000000000000000 806e
1 10076683 23 0e 00 0d 0000000000000100 80ae
1 fe530c23 24 06 05 00 fffffffffffffff8 8010
1 00741123 25 08 07 00 0000000000000002 8050
1 06952223 26 0a 09 00 0000000000000064 8090
1 7eb63c23 27 0c 0b 00 00000000000007f8 80d0
0 fe530c23 00 00 00 00 0000000000000000 0000
0 00000000 00 00 00 00 0000000000000000 0000
1 fe208ee3 28 01 02 00 fffffffffffffffc 8100
1 0062c0e3 2a 05 06 00 0000000000000800 8100
1 80a4e063 2c 09 0a 00 fffffffffffff000 8100
1 00419863 29 03 04 00 0000000000000010 8100
1 ff9ff0ef 2e 00 00 01 fffffffffffffff8 8204
1 ff0280e7 2f 05 00 01 fffffffffffffff0 8304
1 12345537 30 00 00 0a 0000000012345000 8004
1 fffff197 31 00 00 03 fffffffffffff000 8404
0 12345537 00 00 00 00 0000000000000000 0000
1 023100b3 00 00 00 00 0000000000000000 0000
1 023140bb 00 00 00 00 0000000000000000 0000
1 300110f3 00 00 00 00 0000000000000000 0000
1 00000073 00 00 00 00 0000000000000000 0000
1 00007083 00 00 00 00 0000000000000000 0000
1 00004023 00 00 00 00 0000000000000000 0000
1 0200109b 00 00 00 00 0000000000000000 0000

// File: flow_mem_decoder.sv
`timescale 1ns/10ps

module flow_mem_decoder (
    input  rv_decode_pkg::instr_word_t    instr,
    output rv_decode_pkg::decode_result_t result
);
    import rv_decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] f3;

    assign opcode = instr[6:0];
    assign f3     = instr[14:12];

    always_comb begin
        result = '0;
        unique case (opcode)
            OPC_LOAD: begin
                result.imm_fmt            = IMM_I;
                result.uses_rs1           = 1'b1;
                result.ctl.memr_en        = 1'b1;
                result.ctl.regwrite_en    = 1'b1;
                result.ctl.writeback_src  = WB_MEM;
                result.ctl.msize          = msize_t'(f3[1:0]); // Size is log2 of bytes.
                result.ctl.mem_unsigned   = f3[2];
                unique case (f3)
                    F3_LB:   result.op = OP_LB;
                    F3_LH:   result.op = OP_LH;
                    F3_LW:   result.op = OP_LW;
                    F3_LD:   result.op = OP_LD;
                    F3_LBU:  result.op = OP_LBU;
                    F3_LHU:  result.op = OP_LHU;
                    F3_LWU:  result.op = OP_LWU;
                    default: result.op = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                result.imm_fmt     = IMM_S;
                result.uses_rs1    = 1'b1;
                result.uses_rs2    = 1'b1;
                result.ctl.memw_en = 1'b1;
                result.ctl.msize   = msize_t'(f3[1:0]);
                unique case (f3)
                    F3_SB:   result.op = OP_SB;
                    F3_SH:   result.op = OP_SH;
                    F3_SW:   result.op = OP_SW;
                    F3_SD:   result.op = OP_SD;
                    default: result.op = OP_NONE;
                endcase
            end
            OPC_BRANCH: begin
                result.imm_fmt  = IMM_B;
                result.uses_rs1 = 1'b1;
                result.uses_rs2 = 1'b1;
                result.ctl.bj   = BJ_BRANCH;
                unique case (f3)
                    F3_BEQ:  result.op = OP_BEQ;
                    F3_BNE:  result.op = OP_BNE;
                    F3_BLT:  result.op = OP_BLT;
                    F3_BGE:  result.op = OP_BGE;
                    F3_BLTU: result.op = OP_BLTU;
                    F3_BGEU: result.op = OP_BGEU;
                    default: result.op = OP_NONE;
                endcase
            end
            OPC_JALR: begin
                result.op              = (f3 == F3_JALR) ? OP_JALR : OP_NONE;
                result.imm_fmt         = IMM_I;
                result.uses_rs1        = 1'b1;
                result.ctl.bj          = BJ_JALR;
                result.ctl.regwrite_en = 1'b1;
            end
            OPC_JAL: begin
                result.op              = OP_JAL;
                result.imm_fmt         = IMM_J;
                result.ctl.bj          = BJ_JAL;
                result.ctl.regwrite_en = 1'b1;
            end
            OPC_LUI: begin
                result.op              = OP_LUI;
                result.imm_fmt         = IMM_U;
                result.ctl.regwrite_en = 1'b1;
            end
            OPC_AUIPC: begin
                result.op              = OP_AUIPC;
                result.imm_fmt         = IMM_U;
                result.ctl.bj          = BJ_AUIPC; // PC-relative add.
                result.ctl.regwrite_en = 1'b1;
            end
            default: result = '0;
        endcase

        // Illegal funct3 leaves nothing behind.
        if (result.op == OP_NONE) begin
            result = '0;
        end else begin
            result.hit        = 1'b1;
            result.ctl.alusrc = SRC_IMM;
            result.ctl.aluop  = ALU_ADD;
        end
    end

endmodule

// File: imm_gen.sv
`timescale 1ns/10ps

module imm_gen (
    input  rv_decode_pkg::instr_word_t instr,
    input  rv_decode_pkg::imm_fmt_t    fmt,
    output rv_decode_pkg::word_t       imm
);
    import rv_decode_pkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        imm = '0;
        unique case (fmt)
            IMM_I: begin
                imm = {{(XLEN-12){sign}}, instr[31:20]};
            end
            IMM_SHAMT6: begin
                imm = {{(XLEN-6){1'b0}}, instr[25:20]}; // RV64 shift amount.
            end
            IMM_SHAMT5: begin
                imm = {{(XLEN-5){1'b0}}, instr[24:20]};
            end
            IMM_S: begin
                imm = {{(XLEN-12){sign}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                // Bit 0 is always zero.
                imm = {{(XLEN-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {{(XLEN-32){sign}}, instr[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{(XLEN-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int XLEN = 64;

    typedef logic [31:0]     instr_word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [XLEN-1:0] word_t;

    // Major opcodes.
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;

    // Arithmetic funct3 for both immediate and register forms.
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;
    localparam logic [2:0] F3_SD = 3'b011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and arithmetic shifts.

    typedef enum logic [6:0] {
        OP_NONE = 7'd0,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
        OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
        OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
        OP_SB, OP_SH, OP_SW, OP_SD,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR, OP_LUI, OP_AUIPC
    } op_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLW, ALU_SRLW, ALU_SRAW
    } alu_op_t;

    typedef enum logic {SRC_REG, SRC_IMM} alu_src_t;

    typedef enum logic [2:0] {BJ_NONE, BJ_BRANCH, BJ_JAL, BJ_JALR, BJ_AUIPC} bj_t;

    typedef enum logic [1:0] {MSIZE1, MSIZE2, MSIZE4, MSIZE8} msize_t;

    typedef enum logic {WB_ALU, WB_MEM} wb_src_t;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_SHAMT6, IMM_SHAMT5, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_fmt_t;

    typedef struct packed {
        alu_src_t alusrc;
        alu_op_t  aluop;
        bj_t      bj;
        msize_t   msize;
        logic     memr_en;
        logic     memw_en;
        logic     mem_unsigned;
        logic     regwrite_en;
        wb_src_t  writeback_src;
        logic     is_32instr;
    } control_t;

    typedef struct packed {
        logic     hit;
        op_t      op;
        imm_fmt_t imm_fmt;
        logic     uses_rs1;
        logic     uses_rs2;
        control_t ctl;
    } decode_result_t;

    typedef struct packed {
        op_t       op;
        reg_addr_t ra1;
        reg_addr_t ra2;
        reg_addr_t writereg;
        word_t     imm;
        control_t  ctl;
    } decoded_instr_t;

endpackage

// File: vlog.f
rv_decode_pkg.sv
imm_gen.sv
alu_decoder.sv
flow_mem_decoder.sv
decode_stage.sv
clk_gen.sv
decode_chk.sv
decode_tb.sv
